// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       := odt_gen_tb
FILELIST  := vlog.f
OBJ_DIR   := obj_dir
PASS_MSG  := *** PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# exit status is set by whether the pass message shows up in the output
run: compile
	./$(OBJ_DIR)/V$(TOP) | awk -v msg='$(PASS_MSG)' \
		'{ print } index($$0, msg) { ok = 1 } END { exit !ok }'

clean:
	rm -rf $(OBJ_DIR)

// ==== common/odt_macros.svh ====
// DDR3 ODT widths and timing for a half-rate controller; the read pipe depth must be 2**ODT_TCL_W
`ifndef ODT_MACROS_SVH
`define ODT_MACROS_SVH

// configuration field widths
`define ODT_TCL_W 4
`define ODT_CWL_W 4

// read delay pipe covers every tcl value
`define ODT_READ_PIPE_DEPTH 16

// two memory-clock phases per controller clock
`define ODT_PHASES_PER_CLK 2

// ODT high time in memory cycles, BL8 and BC4
`define ODT_HOLD_BL8 6
`define ODT_HOLD_BC4 4

// hold counter only has to reach the BL8 limit of 2
`define ODT_COUNT_W 2

`endif

// ==== common/odt_pkg.sv ====
// ODT generator types; widths come from odt_macros.svh and must agree with the DDR3 mode registers
`include "odt_macros.svh"

package odt_pkg;

    typedef logic [`ODT_TCL_W-1:0]   tcl_t;
    typedef logic [`ODT_CWL_W-1:0]   cwl_t;
    // tcl minus cwl, never negative in a legal setup
    typedef logic [`ODT_TCL_W-1:0]   lat_diff_t;
    typedef logic [`ODT_COUNT_W-1:0] hold_count_t;

    // single-cycle strobes from the bank scheduler
    typedef struct packed {
        logic do_write;
        logic do_read;
        logic burst_chop;
    } odt_cmd_t;

    // quasi-static, only changed while no window is open
    typedef struct packed {
        tcl_t tcl;
        cwl_t cwl;
        logic output_regd;
    } odt_cfg_t;

    // odt_h is the first memory-clock phase, odt_l the second
    typedef struct packed {
        logic odt_h;
        logic odt_l;
    } odt_pins_t;

endpackage

// ==== odt_gen/odt_burst_timer.sv ====
// ODT hold window counter for one command stream; a new go restarts the window
`timescale 1ns/100ps
`include "odt_macros.svh"

module odt_burst_timer
(
    input  logic ctl_clk,
    input  logic ctl_reset_n,
    input  logic go,
    input  logic chop,
    output logic busy
);

    // hold time in controller clocks, minus the strobe cycle itself
    localparam odt_pkg::hold_count_t limit_bl8 =
        odt_pkg::hold_count_t'(`ODT_HOLD_BL8 / `ODT_PHASES_PER_CLK - 1);
    localparam odt_pkg::hold_count_t limit_bc4 =
        odt_pkg::hold_count_t'(`ODT_HOLD_BC4 / `ODT_PHASES_PER_CLK - 1);

    logic                 chop_q;
    odt_pkg::hold_count_t count;
    odt_pkg::hold_count_t limit;

    always_ff @(posedge ctl_clk or negedge ctl_reset_n)
    begin
        if (!ctl_reset_n)
        begin
            chop_q <= 1'b0;
        end
        else if (go)
        begin
            chop_q <= chop;
        end
    end

    assign limit = chop_q ? limit_bc4 : limit_bl8;

    always_ff @(posedge ctl_clk or negedge ctl_reset_n)
    begin
        if (!ctl_reset_n)
        begin
            count <= '0;
        end
        else if (go)
        begin
            count <= odt_pkg::hold_count_t'(1);
        end
        else if (count >= limit)
        begin
            count <= '0;
        end
        else if (count != '0)
        begin
            count <= count + 1'b1;
        end
    end

    assign busy = (count != '0);

    a_count_range : assert property (
        @(posedge ctl_clk) disable iff (!ctl_reset_n)
        count <= limit_bl8
    );

endmodule

// ==== odt_gen/odt_gen_top.sv ====
// DDR3 half-rate ODT generator; read and write windows must not overlap, cfg changes only when idle
`timescale 1ns/100ps

module odt_gen_top
(
    input  logic               ctl_clk,
    input  logic               ctl_reset_n,
    input  odt_pkg::odt_cfg_t  cfg,
    input  odt_pkg::odt_cmd_t  cmd,
    output odt_pkg::odt_pins_t odt
);

    logic rd_go;
    logic rd_chop;
    logic odd_diff;
    logic wr_busy;
    logic rd_busy;

    odt_read_align read_align_i (
        .ctl_clk     (ctl_clk),
        .ctl_reset_n (ctl_reset_n),
        .cfg         (cfg),
        .cmd         (cmd),
        .rd_go       (rd_go),
        .rd_chop     (rd_chop),
        .odd_diff    (odd_diff)
    );

    // writes take the raw strobe and chop bit
    odt_burst_timer wr_timer_i (
        .ctl_clk     (ctl_clk),
        .ctl_reset_n (ctl_reset_n),
        .go          (cmd.do_write),
        .chop        (cmd.burst_chop),
        .busy        (wr_busy)
    );

    odt_burst_timer rd_timer_i (
        .ctl_clk     (ctl_clk),
        .ctl_reset_n (ctl_reset_n),
        .go          (rd_go),
        .chop        (rd_chop),
        .busy        (rd_busy)
    );

    odt_phase_gen phase_gen_i (
        .ctl_clk     (ctl_clk),
        .ctl_reset_n (ctl_reset_n),
        .wr_go       (cmd.do_write),
        .rd_go       (rd_go),
        .wr_busy     (wr_busy),
        .rd_busy     (rd_busy),
        .odd_diff    (odd_diff),
        .output_regd (cfg.output_regd),
        .odt         (odt)
    );

endmodule

// ==== odt_gen/odt_phase_gen.sv ====
// Half-rate ODT pin builder; output_regd adds one cycle to both phases and must be quasi-static
`timescale 1ns/100ps

module odt_phase_gen
(
    input  logic               ctl_clk,
    input  logic               ctl_reset_n,
    input  logic               wr_go,
    input  logic               rd_go,
    input  logic               wr_busy,
    input  logic               rd_busy,
    input  logic               odd_diff,
    input  logic               output_regd,
    output odt_pkg::odt_pins_t odt
);

    logic premux_odt_h;
    logic premux_odt_h_r;
    logic rd_busy_r;
    logic odt_h_int;
    logic odt_l_int;
    logic odt_h_int_r;
    logic odt_l_int_r;

    // unshifted high phase, open in the strobe cycle itself
    assign premux_odt_h = wr_go | rd_go | wr_busy | rd_busy;

    // odd read difference lands half a clock late, so the high phase
    // follows one clock behind the read window
    always_ff @(posedge ctl_clk or negedge ctl_reset_n)
    begin
        if (!ctl_reset_n)
        begin
            premux_odt_h_r <= 1'b0;
            rd_busy_r      <= 1'b0;
        end
        else
        begin
            premux_odt_h_r <= rd_go | (rd_busy & odd_diff);
            rd_busy_r      <= rd_busy;
        end
    end

    always_comb
    begin
        if (odd_diff && (rd_go || rd_busy_r))
        begin
            odt_h_int = premux_odt_h_r;
        end
        else
        begin
            odt_h_int = premux_odt_h;
        end
    end

    // low phase trails the high phase by one clock for both reads and writes
    always_ff @(posedge ctl_clk or negedge ctl_reset_n)
    begin
        if (!ctl_reset_n)
        begin
            odt_l_int <= 1'b0;
        end
        else
        begin
            odt_l_int <= wr_go | rd_go | wr_busy | rd_busy;
        end
    end

    // optional extra output stage
    always_ff @(posedge ctl_clk or negedge ctl_reset_n)
    begin
        if (!ctl_reset_n)
        begin
            odt_h_int_r <= 1'b0;
            odt_l_int_r <= 1'b0;
        end
        else
        begin
            odt_h_int_r <= odt_h_int;
            odt_l_int_r <= odt_l_int;
        end
    end

    assign odt.odt_h = output_regd ? odt_h_int_r : odt_h_int;
    assign odt.odt_l = output_regd ? odt_l_int_r : odt_l_int;

    // aligned read and raw write come from different blocks
    a_no_rd_wr_overlap : assert property (
        @(posedge ctl_clk) disable iff (!ctl_reset_n)
        !(wr_go && rd_go)
    );

endmodule

// ==== odt_gen/odt_read_align.sv ====
// Read ODT aligner; needs tcl >= cwl and a stable cfg for 3 cycles before the next read
`timescale 1ns/100ps
`include "odt_macros.svh"

module odt_read_align
(
    input  logic              ctl_clk,
    input  logic              ctl_reset_n,
    input  odt_pkg::odt_cfg_t cfg,
    input  odt_pkg::odt_cmd_t cmd,
    output logic              rd_go,
    output logic              rd_chop,
    output logic              odd_diff
);

    odt_pkg::lat_diff_t diff;
    odt_pkg::lat_diff_t sel_unreg;
    odt_pkg::lat_diff_t sel;
    logic               diff_small;

    logic [`ODT_READ_PIPE_DEPTH-1:0] rd_pipe;
    logic [`ODT_READ_PIPE_DEPTH-1:0] chop_pipe;

    // ODTLon/ODTLoff follow cwl, so reads have to wait tcl - cwl memory cycles
    always_ff @(posedge ctl_clk or negedge ctl_reset_n)
    begin
        if (!ctl_reset_n)
        begin
            diff <= '0;
        end
        else
        begin
            diff <= cfg.tcl - cfg.cwl;
        end
    end

    // two memory cycles per clock, so the delay is half the difference rounded up
    // tap 0 is already one clock late, hence the minus one below
    assign sel_unreg = (diff >> 1) + odt_pkg::lat_diff_t'(diff[0]);

    always_ff @(posedge ctl_clk or negedge ctl_reset_n)
    begin
        if (!ctl_reset_n)
        begin
            sel        <= '0;
            diff_small <= 1'b1;
            odd_diff   <= 1'b0;
        end
        else
        begin
            diff_small <= (diff < odt_pkg::lat_diff_t'(`ODT_PHASES_PER_CLK));
            odd_diff   <= diff[0];
            if (sel_unreg != '0)
            begin
                sel <= sel_unreg - 1'b1;
            end
            else
            begin
                sel <= '0;
            end
        end
    end

    // several reads may be in flight at once
    always_ff @(posedge ctl_clk or negedge ctl_reset_n)
    begin
        if (!ctl_reset_n)
        begin
            rd_pipe <= '0;
        end
        else
        begin
            rd_pipe <= {rd_pipe[`ODT_READ_PIPE_DEPTH-2:0], cmd.do_read};
        end
    end

    always_ff @(posedge ctl_clk)
    begin
        chop_pipe <= {chop_pipe[`ODT_READ_PIPE_DEPTH-2:0], cmd.burst_chop};
    end

    assign rd_go   = diff_small ? cmd.do_read    : rd_pipe[sel];
    assign rd_chop = diff_small ? cmd.burst_chop : chop_pipe[sel];

    a_tcl_ge_cwl : assert property (
        @(posedge ctl_clk) disable iff (!ctl_reset_n)
        cfg.tcl >= cfg.cwl
    );

endmodule

// ==== test/odt_gen_tb.sv ====
// Table-driven testbench for odt_gen_top; assumes windows never overlap and cfg only changes when idle
`timescale 1ns/100ps
`include "odt_macros.svh"

module odt_gen_tb;

    localparam int clk_period    = 100;
    localparam int reset_cycles  = 16;
    localparam int settle_cycles = 4;
    localparam int num_fixed     = 17;
    localparam int num_random    = 6;
    localparam int num_tests     = num_fixed + num_random;
    localparam int cmd_none      = 0;
    localparam int cmd_write     = 1;
    localparam int cmd_read      = 2;

    logic               ctl_clk = 1'b0;
    logic               ctl_reset_n;
    odt_pkg::odt_cfg_t  cfg;
    odt_pkg::odt_cmd_t  cmd;
    odt_pkg::odt_pins_t odt;

    // stimulus table, one row per test
    string             tbl_name [num_tests];
    odt_pkg::odt_cfg_t tbl_cfg  [num_tests];
    int                tbl_kind [num_tests];
    logic              tbl_chop [num_tests];
    int                tbl_gap  [num_tests];

    int   n_entries   = 0;
    int   errors      = 0;
    int   checks      = 0;
    int   seed        = 32'h0c1c902a;
    logic table_ready = 1'b0;

    odt_gen_top dut_i (
        .ctl_clk     (ctl_clk),
        .ctl_reset_n (ctl_reset_n),
        .cfg         (cfg),
        .cmd         (cmd),
        .odt         (odt)
    );

    always #(clk_period / 2) ctl_clk = ~ctl_clk;

    task automatic add_entry(string name, int tcl, int cwl, logic regd, int kind, logic chop,
                             int gap);
        tbl_name[n_entries]             = name;
        tbl_cfg[n_entries].tcl          = odt_pkg::tcl_t'(tcl);
        tbl_cfg[n_entries].cwl          = odt_pkg::cwl_t'(cwl);
        tbl_cfg[n_entries].output_regd  = regd;
        tbl_kind[n_entries]             = kind;
        tbl_chop[n_entries]             = chop;
        tbl_gap[n_entries]              = gap;
        n_entries++;
    endtask

    task automatic build_table();
        int r;
        int t;
        int w;
        int n;
        add_entry("idle_after_reset", 5, 5, 1'b0, cmd_none, 1'b0, 8);
        add_entry("wr_bl8", 6, 5, 1'b0, cmd_write, 1'b0, 16);
        add_entry("wr_bc4", 6, 5, 1'b0, cmd_write, 1'b1, 16);
        add_entry("rd_even0", 5, 5, 1'b0, cmd_read, 1'b0, 16);
        add_entry("rd_even2", 7, 5, 1'b0, cmd_read, 1'b1, 16);
        add_entry("rd_even6", 11, 5, 1'b0, cmd_read, 1'b0, 16);
        add_entry("rd_odd1", 6, 5, 1'b0, cmd_read, 1'b0, 16);
        add_entry("rd_odd3", 8, 5, 1'b0, cmd_read, 1'b1, 16);
        add_entry("rd_odd5", 10, 5, 1'b0, cmd_read, 1'b0, 16);
        add_entry("wr_bl8_regd", 6, 5, 1'b1, cmd_write, 1'b0, 16);
        add_entry("wr_bc4_regd", 6, 5, 1'b1, cmd_write, 1'b1, 16);
        add_entry("rd_even0_regd", 5, 5, 1'b1, cmd_read, 1'b0, 16);
        add_entry("rd_even2_regd", 7, 5, 1'b1, cmd_read, 1'b0, 16);
        add_entry("rd_even6_regd", 11, 5, 1'b1, cmd_read, 1'b1, 16);
        add_entry("rd_odd3_regd", 8, 5, 1'b1, cmd_read, 1'b1, 16);
        add_entry("rd_odd1_regd", 6, 5, 1'b1, cmd_read, 1'b1, 16);
        add_entry("rd_odd5_regd", 10, 5, 1'b1, cmd_read, 1'b0, 16);
        // random latencies, cwl kept at or below tcl
        for (n = 0; n < num_random; n++)
        begin
            r = $random(seed);
            t = r & 15;
            r = $random(seed);
            w = int'($unsigned(r) % (t + 1));
            r = $random(seed);
            add_entry($sformatf("rand_%0d", n), t, w, r[2], r[0] ? cmd_read : cmd_write,
                      r[1], 16);
        end
    endtask

    // expected pins k cycles after the command was issued
    function automatic odt_pkg::odt_pins_t expected_pins(odt_pkg::odt_cfg_t c, int kind,
                                                         logic chop, int k);
        odt_pkg::odt_pins_t p;
        int lim;
        int diff;
        int delay;
        int h_start;
        int l_start;
        lim   = (chop ? `ODT_HOLD_BC4 : `ODT_HOLD_BL8) / `ODT_PHASES_PER_CLK - 1;
        diff  = int'(c.tcl) - int'(c.cwl);
        delay = 0;
        if (kind == cmd_read && diff >= 2)
        begin
            delay = (diff + 1) / 2;
        end
        h_start = delay;
        // odd read difference pushes the high phase into the next clock
        if (kind == cmd_read && (diff % 2) == 1)
        begin
            h_start = delay + 1;
        end
        l_start = delay + 1;
        if (c.output_regd)
        begin
            h_start++;
            l_start++;
        end
        p = '0;
        if (kind != cmd_none)
        begin
            p.odt_h = (k >= h_start) && (k <= h_start + lim);
            p.odt_l = (k >= l_start) && (k <= l_start + lim);
        end
        return p;
    endfunction

    task automatic check_pins(string name, int cyc, odt_pkg::odt_pins_t exp_v,
                              odt_pkg::odt_pins_t act);
        checks++;
        if (act !== exp_v)
        begin
            errors++;
            $display("[FAIL] %s cycle %0d: expected odt=%b actual odt=%b", name, cyc, exp_v, act);
        end
    endtask

    // new cfg, a few idle cycles to settle, the command, then the idle gap
    task automatic run_entry(int idx);
        odt_pkg::odt_cmd_t c;
        int k;
        for (k = -settle_cycles; k <= tbl_gap[idx]; k++)
        begin
            @(negedge ctl_clk);
            c = '0;
            if (k == 0)
            begin
                c.do_write   = (tbl_kind[idx] == cmd_write);
                c.do_read    = (tbl_kind[idx] == cmd_read);
                c.burst_chop = tbl_chop[idx];
            end
            if (k == -settle_cycles)
            begin
                cfg = tbl_cfg[idx];
            end
            cmd = c;
            // sample a quarter period later, well clear of both edges
            #(clk_period / 4);
            check_pins(tbl_name[idx], k,
                       expected_pins(tbl_cfg[idx], tbl_kind[idx], tbl_chop[idx], k), odt);
        end
    endtask

    initial
    begin
        int i;
        ctl_reset_n = 1'b0;
        cfg         = '0;
        cmd         = '0;
        build_table();
        table_ready = 1'b1;
        for (i = 0; i < reset_cycles - 1; i++)
        begin
            @(negedge ctl_clk);
            #(clk_period / 4);
            check_pins("reset", i, '0, odt);
        end
        @(negedge ctl_clk);
        ctl_reset_n = 1'b1;
        for (i = 0; i < n_entries; i++)
        begin
            run_entry(i);
        end
        $display("checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0)
        begin
            $display("*** PASSED ***");
        end
        else
        begin
            $display("*** FAILED ***");
        end
        $finish;
    end

    // limit the run to the length of the table plus some margin
    initial
    begin
        int budget;
        int i;
        wait (table_ready);
        budget = reset_cycles + 64;
        for (i = 0; i < n_entries; i++)
        begin
            budget += settle_cycles + 1 + tbl_gap[i];
        end
        #(budget * clk_period);
        $display("watchdog: the tests did not finish within %0d clock cycles", budget);
        $display("checks run: %0d, errors: %0d", checks, errors);
        $display("*** FAILED ***");
        $finish;
    end

endmodule

// ==== vlog.f ====
+incdir+common
common/odt_pkg.sv
odt_gen/odt_read_align.sv
odt_gen/odt_burst_timer.sv
odt_gen/odt_phase_gen.sv
odt_gen/odt_gen_top.sv
test/odt_gen_tb.sv
